//--- verilog.f
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/apb_debug.sv
logic/processor.sv
verif/tb_clock_gen.sv
verif/processor_tb.sv

//--- Bender.yml
package:
  name: processor

sources:
  - logic/cpu_pkg.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/memory_stage.sv
  - logic/apb_debug.sv
  - logic/processor.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/processor_tb.sv

//--- verif/processor_tb.sv
`timescale 1ns/1ps

module processor_tb;

  localparam int  num_rows    = 5;
  localparam int  prog_len    = 12;
  localparam int  poll_limit  = 80;
  localparam time watchdog_ns = num_rows * 400 * 20;

  logic        clk;
  logic        rst_n;
  logic [11:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  // one row per program
  logic [31:0]      prog_tab      [num_rows][prog_len];
  logic [3:0][31:0] dmem_init_tab [num_rows];
  logic [3:0][31:0] exp_dmem_tab  [num_rows];
  logic [7:0][31:0] exp_reg_tab   [num_rows];
  logic [7:0]       reg_mask_tab  [num_rows];
  bit               poke_tab      [num_rows];
  string            name_tab      [num_rows];

  logic [31:0] rng_state;
  int          errors;
  int          pass_count;
  int          fail_count;

  tb_clock_gen clock_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  processor processor_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // rd gets rs op rt
  function automatic logic [31:0] rtype(input logic [5:0] op, input int rd, input int rs,
                                        input int rt);
    return {op, rs[4:0], rt[4:0], rd[4:0], 11'd0};
  endfunction

  function automatic logic [31:0] itype(input logic [5:0] op, input int rt, input int rs,
                                        input logic [15:0] imm);
    return {op, rs[4:0], rt[4:0], imm};
  endfunction

  function automatic logic [11:0] word_addr(input logic [11:0] base, input int idx);
    return base + 12'(4 * idx);
  endfunction

  //////////////////////////////
  // apb access

  task automatic transfer(input logic write, input logic [11:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    // outputs settled in the access phase
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    if (pready !== 1'b1) begin
      $display("Mismatch pready: expected 0x1, got 0x%0h", pready);
      errors++;
    end
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_word(input logic [11:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic read_word(input logic [11:0] addr, output logic [31:0] data, output logic err);
    transfer(1'b0, addr, 32'h0, data, err);
  endtask

  //////////////////////////////
  // sequential isa model

  task automatic model_run(input int row);
    logic [31:0] regs [32];
    logic [31:0] mem  [64];
    logic [31:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ext;
    logic [5:0]  op;
    logic [5:0]  idx;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < 64; i++) mem[i] = (i < 4) ? dmem_init_tab[row][i] : '0;
    for (int pc = 0; pc < prog_len; pc++) begin
      instr = prog_tab[row][pc];
      op    = instr[31:26];
      a     = regs[instr[25:21]];
      b     = regs[instr[20:16]];
      ext   = {16'd0, instr[15:0]};
      idx   = a + ext;
      if (op == cpu_pkg::op_halt) break;
      case (op)
        cpu_pkg::op_add:  regs[instr[15:11]] = a + b;
        cpu_pkg::op_sub:  regs[instr[15:11]] = a - b;
        cpu_pkg::op_and:  regs[instr[15:11]] = a & b;
        cpu_pkg::op_or:   regs[instr[15:11]] = a | b;
        cpu_pkg::op_xor:  regs[instr[15:11]] = a ^ b;
        cpu_pkg::op_slt:  regs[instr[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        cpu_pkg::op_addi: regs[instr[20:16]] = a + ext;
        cpu_pkg::op_lw:   regs[instr[20:16]] = mem[idx];
        cpu_pkg::op_sw:   mem[idx] = b;
        default: ;
      endcase
      regs[0] = '0;
    end
    for (int i = 0; i < 8; i++) exp_reg_tab[row][i] = regs[i];
    for (int i = 0; i < 4; i++) exp_dmem_tab[row][i] = mem[i];
  endtask

  // sources only from registers already written
  task automatic build_random_row(input int row);
    int         written [8];
    int         n_written;
    int         k;
    int         dst;
    int         rs;
    int         rt;
    logic [5:0] op;
    logic [7:0] mask;
    written[0] = 0;
    n_written  = 1;
    mask       = 8'h01;
    for (int i = 0; i < 10; i++) begin
      rng_state = xorshift(rng_state);
      k = rng_state % 7;
      case (k)
        0:       op = cpu_pkg::op_add;
        1:       op = cpu_pkg::op_sub;
        2:       op = cpu_pkg::op_and;
        3:       op = cpu_pkg::op_or;
        4:       op = cpu_pkg::op_xor;
        5:       op = cpu_pkg::op_slt;
        default: op = cpu_pkg::op_addi;
      endcase
      rng_state = xorshift(rng_state);
      dst = 1 + rng_state % 7;
      rng_state = xorshift(rng_state);
      rs = written[rng_state % n_written];
      rng_state = xorshift(rng_state);
      rt = written[rng_state % n_written];
      if (op == cpu_pkg::op_addi) begin
        prog_tab[row][i] = itype(op, dst, rs, rng_state[31:16]);
      end else begin
        prog_tab[row][i] = rtype(op, dst, rs, rt);
      end
      if (!mask[dst]) begin
        written[n_written] = dst;
        n_written++;
        mask[dst] = 1'b1;
      end
    end
    for (int i = 0; i < 4; i++) begin
      rng_state = xorshift(rng_state);
      dmem_init_tab[row][i] = rng_state;
    end
    reg_mask_tab[row] = mask;
    model_run(row);
  endtask

  //////////////////////////////
  // program table

  task automatic build_table();
    for (int r = 0; r < num_rows; r++) begin
      for (int i = 0; i < prog_len; i++) prog_tab[r][i] = {cpu_pkg::op_halt, 26'd0};
      poke_tab[r] = 1'b0;
    end

    // dependent chain over both forwarding paths and r0 writes
    name_tab[0]      = "forward_chain";
    prog_tab[0][0]   = itype(cpu_pkg::op_addi, 1, 0, 16'd5);
    prog_tab[0][1]   = itype(cpu_pkg::op_addi, 2, 1, 16'd3);
    prog_tab[0][2]   = rtype(cpu_pkg::op_add, 3, 1, 2);
    prog_tab[0][3]   = rtype(cpu_pkg::op_sub, 4, 3, 1);
    prog_tab[0][4]   = rtype(cpu_pkg::op_xor, 5, 4, 2);
    prog_tab[0][5]   = rtype(cpu_pkg::op_or, 5, 3, 4);
    prog_tab[0][6]   = rtype(cpu_pkg::op_and, 6, 5, 2);
    prog_tab[0][7]   = rtype(cpu_pkg::op_slt, 7, 4, 3);
    prog_tab[0][8]   = itype(cpu_pkg::op_addi, 0, 3, 16'd7);
    prog_tab[0][9]   = rtype(cpu_pkg::op_add, 1, 0, 3);
    prog_tab[0][10]  = rtype(cpu_pkg::op_sub, 2, 0, 1);
    dmem_init_tab[0] = {32'h4, 32'h3, 32'h2, 32'h1};
    exp_dmem_tab[0]  = dmem_init_tab[0];
    exp_reg_tab[0]   = {32'd1, 32'd8, 32'd13, 32'd8, 32'd13, 32'hfffffff3, 32'd13, 32'd0};
    reg_mask_tab[0]  = 8'hff;

    // loads used at once on rs, rt and as store data
    name_tab[1]      = "load_use";
    prog_tab[1][0]   = itype(cpu_pkg::op_addi, 1, 0, 16'd1);
    prog_tab[1][1]   = itype(cpu_pkg::op_lw, 2, 1, 16'd0);
    prog_tab[1][2]   = rtype(cpu_pkg::op_add, 3, 2, 1);
    prog_tab[1][3]   = itype(cpu_pkg::op_lw, 4, 1, 16'd1);
    prog_tab[1][4]   = rtype(cpu_pkg::op_add, 5, 1, 4);
    prog_tab[1][5]   = itype(cpu_pkg::op_lw, 6, 0, 16'd0);
    prog_tab[1][6]   = itype(cpu_pkg::op_sw, 6, 0, 16'd3);
    dmem_init_tab[1] = {32'h0, 32'ha, 32'h12345678, 32'h64};
    exp_dmem_tab[1]  = {32'h64, 32'ha, 32'h12345678, 32'h64};
    exp_reg_tab[1]   = {32'h0, 32'h64, 32'hb, 32'ha, 32'h12345679, 32'h12345678, 32'h1, 32'h0};
    reg_mask_tab[1]  = 8'h7f;

    // store then load and nothing after the halt
    name_tab[2]      = "store_load_halt";
    prog_tab[2][0]   = itype(cpu_pkg::op_addi, 1, 0, 16'h1234);
    prog_tab[2][1]   = itype(cpu_pkg::op_addi, 2, 0, 16'd1);
    prog_tab[2][2]   = rtype(cpu_pkg::op_add, 3, 2, 2);
    prog_tab[2][3]   = itype(cpu_pkg::op_sw, 1, 3, 16'd0);
    prog_tab[2][4]   = itype(cpu_pkg::op_lw, 4, 3, 16'd0);
    prog_tab[2][5]   = itype(cpu_pkg::op_addi, 5, 4, 16'hffff);
    prog_tab[2][6]   = itype(cpu_pkg::op_addi, 6, 0, 16'h55);
    prog_tab[2][8]   = itype(cpu_pkg::op_addi, 6, 0, 16'h77);
    prog_tab[2][9]   = itype(cpu_pkg::op_sw, 1, 0, 16'd0);
    dmem_init_tab[2] = {32'hd3d3d3d3, 32'hc2c2c2c2, 32'hb1b1b1b1, 32'ha0a0a0a0};
    exp_dmem_tab[2]  = {32'hd3d3d3d3, 32'h1234, 32'hb1b1b1b1, 32'ha0a0a0a0};
    exp_reg_tab[2]   = {32'h0, 32'h55, 32'h11233, 32'h1234, 32'h2, 32'h1, 32'h1234, 32'h0};
    reg_mask_tab[2]  = 8'h7f;

    // imem poke while running must be refused
    name_tab[3]      = "busy_imem_write";
    poke_tab[3]      = 1'b1;
    prog_tab[3][0]   = itype(cpu_pkg::op_addi, 1, 0, 16'd7);
    prog_tab[3][1]   = itype(cpu_pkg::op_addi, 2, 0, 16'd9);
    prog_tab[3][2]   = rtype(cpu_pkg::op_add, 3, 1, 2);
    prog_tab[3][3]   = rtype(cpu_pkg::op_sub, 4, 2, 1);
    prog_tab[3][4]   = rtype(cpu_pkg::op_slt, 5, 2, 1);
    prog_tab[3][5]   = rtype(cpu_pkg::op_slt, 6, 1, 2);
    prog_tab[3][6]   = rtype(cpu_pkg::op_and, 7, 3, 1);
    prog_tab[3][7]   = rtype(cpu_pkg::op_or, 7, 7, 2);
    prog_tab[3][8]   = rtype(cpu_pkg::op_xor, 1, 1, 2);
    prog_tab[3][9]   = rtype(cpu_pkg::op_add, 2, 1, 1);
    prog_tab[3][10]  = itype(cpu_pkg::op_addi, 3, 3, 16'd4);
    dmem_init_tab[3] = {32'h8, 32'h7, 32'h6, 32'h5};
    exp_dmem_tab[3]  = dmem_init_tab[3];
    exp_reg_tab[3]   = {32'd9, 32'd1, 32'd0, 32'd2, 32'd20, 32'd28, 32'd14, 32'd0};
    reg_mask_tab[3]  = 8'hff;

    name_tab[4] = "random_alu";
    build_random_row(4);
  endtask

  //////////////////////////////
  // load, run and compare one row

  task automatic run_row(input int row);
    logic [31:0] rdata;
    logic        err;
    int          polls;
    bit          done;
    for (int i = 0; i < prog_len; i++) begin
      write_word(word_addr(cpu_pkg::apb_imem_base, i), prog_tab[row][i], err);
      if (err !== 1'b0) begin
        $display("Mismatch pslverr on imem word %0d: expected 0x0, got 0x%0h", i, err);
        errors++;
      end
    end
    for (int i = 0; i < 4; i++) begin
      write_word(word_addr(cpu_pkg::apb_dmem_base, i), dmem_init_tab[row][i], err);
      if (err !== 1'b0) begin
        $display("Mismatch pslverr on dmem word %0d: expected 0x0, got 0x%0h", i, err);
        errors++;
      end
    end
    write_word(cpu_pkg::apb_ctrl_addr, 32'h1, err);
    if (poke_tab[row]) begin
      write_word(word_addr(cpu_pkg::apb_imem_base, 10),
                 itype(cpu_pkg::op_addi, 3, 0, 16'h99), err);
      if (err !== 1'b1) begin
        $display("Mismatch pslverr: expected 0x1, got 0x%0h", err);
        errors++;
      end
    end
    done  = 1'b0;
    polls = 0;
    while (!done && polls < poll_limit) begin
      read_word(cpu_pkg::apb_ctrl_addr, rdata, err);
      done = rdata[1];
      polls++;
    end
    if (!done) begin
      $display("program %s did not report done after %0d status reads", name_tab[row], polls);
      errors++;
    end else begin
      for (int i = 0; i < 8; i++) begin
        if (reg_mask_tab[row][i]) begin
          read_word(word_addr(cpu_pkg::apb_reg_base, i), rdata, err);
          if (rdata !== exp_reg_tab[row][i]) begin
            $display("Mismatch r%0d: expected 0x%08h, got 0x%08h", i, exp_reg_tab[row][i], rdata);
            errors++;
          end
        end
      end
      for (int i = 0; i < 4; i++) begin
        read_word(word_addr(cpu_pkg::apb_dmem_base, i), rdata, err);
        if (rdata !== exp_dmem_tab[row][i]) begin
          $display("Mismatch dmem[%0d]: expected 0x%08h, got 0x%08h", i,
                   exp_dmem_tab[row][i], rdata);
          errors++;
        end
      end
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == 0) begin
      $display("test %s: ok", name);
      pass_count++;
    end else begin
      $display("test %s: %0d error(s)", name, errors);
      fail_count++;
    end
    errors = 0;
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    rng_state  = 32'haa5e24cf;
    errors     = 0;
    pass_count = 0;
    fail_count = 0;
    build_table();
    wait (rst_n === 1'b1);

    // idle status then an unmapped address
    read_word(cpu_pkg::apb_ctrl_addr, rdata, err);
    if (rdata !== 32'h0) begin
      $display("Mismatch status: expected 0x00000000, got 0x%08h", rdata);
      errors++;
    end
    if (err !== 1'b0) begin
      $display("Mismatch pslverr: expected 0x0, got 0x%0h", err);
      errors++;
    end
    read_word(12'h400, rdata, err);
    if (err !== 1'b1) begin
      $display("Mismatch pslverr: expected 0x1, got 0x%0h", err);
      errors++;
    end
    finish_test("reset_status");

    for (int row = 0; row < num_rows; row++) begin
      run_row(row);
      finish_test(name_tab[row]);
    end

    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // 400 cycles per table row
  initial begin
    #(watchdog_ns);
    $display("watchdog expired before all tests finished");
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // low for the first 3 rising edges
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- logic/processor.sv
`timescale 1ns/1ps

module processor (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [cpu_pkg::apb_addr_width-1:0]  paddr,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [cpu_pkg::data_width-1:0]      pwdata,
  output logic [cpu_pkg::data_width-1:0]      prdata,
  output logic                                pready,
  output logic                                pslverr
);

  cpu_pkg::dbg_mem_t                  imem_dbg;
  cpu_pkg::dbg_mem_t                  dmem_dbg;
  logic [cpu_pkg::data_width-1:0]     dmem_rdata;
  logic [cpu_pkg::reg_addr_width-1:0] reg_raddr;
  logic [cpu_pkg::data_width-1:0]     reg_rdata;
  logic                               start;
  logic                               busy;
  logic                               stall;
  logic                               retire_halt;
  cpu_pkg::if_id_t                    if_id;
  cpu_pkg::id_ex_t                    id_ex;
  cpu_pkg::ex_mem_t                   ex_mem;
  cpu_pkg::mem_wb_t                   mem_wb;

  //////////////////////////////
  // pipeline

  fetch_stage fetch_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .busy     (busy),
    .stall    (stall),
    .imem_dbg (imem_dbg),
    .if_id    (if_id)
  );

  decode_stage decode_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .if_id     (if_id),
    .mem_wb    (mem_wb),
    .reg_raddr (reg_raddr),
    .reg_rdata (reg_rdata),
    .stall     (stall),
    .id_ex     (id_ex)
  );

  execute_stage execute_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .id_ex  (id_ex),
    .mem_wb (mem_wb),
    .ex_mem (ex_mem)
  );

  memory_stage memory_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .ex_mem      (ex_mem),
    .dmem_dbg    (dmem_dbg),
    .dmem_rdata  (dmem_rdata),
    .mem_wb      (mem_wb),
    .retire_halt (retire_halt)
  );

  //////////////////////////////
  // debug slave

  apb_debug apb_debug_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .dmem_rdata  (dmem_rdata),
    .reg_rdata   (reg_rdata),
    .retire_halt (retire_halt),
    .imem_dbg    (imem_dbg),
    .dmem_dbg    (dmem_dbg),
    .reg_raddr   (reg_raddr),
    .start       (start),
    .busy        (busy)
  );

endmodule

//--- logic/apb_debug.sv
`timescale 1ns/1ps

module apb_debug (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [cpu_pkg::apb_addr_width-1:0]  paddr,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [cpu_pkg::data_width-1:0]      pwdata,
  output logic [cpu_pkg::data_width-1:0]      prdata,
  output logic                                pready,
  output logic                                pslverr,
  input  logic [cpu_pkg::data_width-1:0]      dmem_rdata,
  input  logic [cpu_pkg::data_width-1:0]      reg_rdata,
  input  logic                                retire_halt,
  output cpu_pkg::dbg_mem_t                   imem_dbg,
  output cpu_pkg::dbg_mem_t                   dmem_dbg,
  output logic [cpu_pkg::reg_addr_width-1:0]  reg_raddr,
  output logic                                start,
  output logic                                busy
);

  logic access;
  logic sel_imem;
  logic sel_dmem;
  logic sel_reg;
  logic sel_ctrl;
  logic mem_ok;
  logic done;

  assign access = psel && penable;

  // address decode
  assign sel_imem = paddr[11:8] == cpu_pkg::apb_imem_base[11:8];
  assign sel_dmem = paddr[11:8] == cpu_pkg::apb_dmem_base[11:8];
  assign sel_reg  = paddr[11:7] == cpu_pkg::apb_reg_base[11:7];
  assign sel_ctrl = paddr == cpu_pkg::apb_ctrl_addr;

  assign mem_ok  = access && !busy;
  assign pready  = 1'b1;
  assign pslverr = access && (!(sel_imem || sel_dmem || sel_reg || sel_ctrl) ||
                              (busy && (sel_imem || sel_dmem || sel_reg)));

  assign imem_dbg.en    = mem_ok && sel_imem;
  assign imem_dbg.write = pwrite;
  assign imem_dbg.addr  = paddr[cpu_pkg::mem_addr_width+1:2];
  assign imem_dbg.wdata = pwdata;

  assign dmem_dbg.en    = mem_ok && sel_dmem;
  assign dmem_dbg.write = pwrite;
  assign dmem_dbg.addr  = paddr[cpu_pkg::mem_addr_width+1:2];
  assign dmem_dbg.wdata = pwdata;

  assign reg_raddr = paddr[cpu_pkg::reg_addr_width+1:2];

  always_comb begin
    prdata = '0;
    if (sel_dmem) begin
      prdata = dmem_rdata;
    end else if (sel_reg) begin
      prdata = reg_rdata;
    end else if (sel_ctrl) begin
      prdata = {{(cpu_pkg::data_width-2){1'b0}}, done, busy};
    end
  end

  // a start while running is ignored
  assign start = mem_ok && pwrite && sel_ctrl && pwdata[0];

  //////////////////////////////
  // run control

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
      done <= 1'b0;
    end else if (retire_halt) begin
      busy <= 1'b0;
      done <= 1'b1;
    end
  end

endmodule

//--- logic/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           start,
  input  cpu_pkg::ex_mem_t               ex_mem,
  input  cpu_pkg::dbg_mem_t              dmem_dbg,
  output logic [cpu_pkg::data_width-1:0] dmem_rdata,
  output cpu_pkg::mem_wb_t               mem_wb,
  output logic                           retire_halt
);

  logic [cpu_pkg::data_width-1:0]     dmem [2**cpu_pkg::mem_addr_width];
  logic [cpu_pkg::mem_addr_width-1:0] addr;
  logic [cpu_pkg::data_width-1:0]     wdata;
  logic [cpu_pkg::data_width-1:0]     rdata;
  logic                               wr_en;

  // debug port only active while idle
  assign addr  = dmem_dbg.en ? dmem_dbg.addr : ex_mem.alu_result[cpu_pkg::mem_addr_width-1:0];
  assign wdata = dmem_dbg.en ? dmem_dbg.wdata : ex_mem.store_data;
  assign wr_en = dmem_dbg.en ? dmem_dbg.write : (ex_mem.valid && ex_mem.mem_write);
  assign rdata = dmem[addr];

  assign dmem_rdata = rdata;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      dmem[addr] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || start) begin
      mem_wb.valid <= 1'b0;
    end else begin
      mem_wb.valid     <= ex_mem.valid;
      mem_wb.reg_write <= ex_mem.reg_write;
      mem_wb.halt      <= ex_mem.halt;
      mem_wb.dst       <= ex_mem.dst;
      mem_wb.wb_data   <= ex_mem.mem_read ? rdata : ex_mem.alu_result;
    end
  end

  assign retire_halt = mem_wb.valid && mem_wb.halt;

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  cpu_pkg::id_ex_t   id_ex,
  input  cpu_pkg::mem_wb_t  mem_wb,
  output cpu_pkg::ex_mem_t  ex_mem
);

  logic [cpu_pkg::data_width-1:0] op_a;
  logic [cpu_pkg::data_width-1:0] op_b;
  logic [cpu_pkg::data_width-1:0] alu_b;
  logic [cpu_pkg::data_width-1:0] alu_result;
  cpu_pkg::ex_mem_t               ex_mem_d;

  // newest producer wins
  function automatic logic [cpu_pkg::data_width-1:0] forward(
    input logic [cpu_pkg::reg_addr_width-1:0] src,
    input logic [cpu_pkg::data_width-1:0]     id_val,
    input cpu_pkg::ex_mem_t                   em,
    input cpu_pkg::mem_wb_t                   mw
  );
    if ((src != '0) && em.valid && em.reg_write && (em.dst == src)) begin
      return em.alu_result;
    end else if ((src != '0) && mw.valid && mw.reg_write && (mw.dst == src)) begin
      return mw.wb_data;
    end else begin
      return id_val;
    end
  endfunction

  assign op_a  = forward(id_ex.rs, id_ex.op_a, ex_mem, mem_wb);
  assign op_b  = forward(id_ex.rt, id_ex.op_b, ex_mem, mem_wb);

  // immediates are zero extended
  assign alu_b = id_ex.ctrl.alu_src ?
                 {{(cpu_pkg::data_width-cpu_pkg::imm_width){1'b0}}, id_ex.imm} : op_b;

  //////////////////////////////
  // alu

  always_comb begin
    case (id_ex.ctrl.alu_op)
      cpu_pkg::alu_add: alu_result = op_a + alu_b;
      cpu_pkg::alu_sub: alu_result = op_a - alu_b;
      cpu_pkg::alu_and: alu_result = op_a & alu_b;
      cpu_pkg::alu_or:  alu_result = op_a | alu_b;
      cpu_pkg::alu_xor: alu_result = op_a ^ alu_b;
      cpu_pkg::alu_slt: begin
        alu_result = {{(cpu_pkg::data_width-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
      end
      default: alu_result = op_a + alu_b;
    endcase
  end

  always_comb begin
    ex_mem_d.valid      = id_ex.valid;
    ex_mem_d.reg_write  = id_ex.ctrl.reg_write;
    ex_mem_d.mem_read   = id_ex.ctrl.mem_read;
    ex_mem_d.mem_write  = id_ex.ctrl.mem_write;
    ex_mem_d.halt       = id_ex.ctrl.halt;
    ex_mem_d.dst        = id_ex.dst;
    ex_mem_d.alu_result = alu_result;
    ex_mem_d.store_data = op_b;
  end

  always_ff @(posedge clk) begin
    if (!rst_n || start) begin
      ex_mem.valid <= 1'b0;
    end else begin
      ex_mem <= ex_mem_d;
    end
  end

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                start,
  input  cpu_pkg::if_id_t                     if_id,
  input  cpu_pkg::mem_wb_t                    mem_wb,
  input  logic [cpu_pkg::reg_addr_width-1:0]  reg_raddr,
  output logic [cpu_pkg::data_width-1:0]      reg_rdata,
  output logic                                stall,
  output cpu_pkg::id_ex_t                     id_ex
);

  logic [cpu_pkg::opcode_width-1:0]   opcode;
  logic [cpu_pkg::reg_addr_width-1:0] rs;
  logic [cpu_pkg::reg_addr_width-1:0] rt;
  logic [cpu_pkg::reg_addr_width-1:0] rd;
  cpu_pkg::ctrl_t                     ctrl;
  logic [cpu_pkg::data_width-1:0]     regs [2**cpu_pkg::reg_addr_width];
  logic [cpu_pkg::data_width-1:0]     rs_data;
  logic [cpu_pkg::data_width-1:0]     rt_data;
  logic                               wb_en;
  logic                               uses_rs;
  logic                               uses_rt;

  assign opcode = if_id.instr[31:26];
  assign rs     = if_id.instr[25:21];
  assign rt     = if_id.instr[20:16];
  assign rd     = if_id.instr[15:11];

  //////////////////////////////
  // control decode

  always_comb begin
    ctrl = '0;
    case (opcode)
      cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
      cpu_pkg::op_or, cpu_pkg::op_xor, cpu_pkg::op_slt: begin
        ctrl.reg_dst   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      cpu_pkg::op_addi: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      cpu_pkg::op_lw: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
      end
      cpu_pkg::op_sw: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      cpu_pkg::op_halt: ctrl.halt = 1'b1;
      default: ;
    endcase
    case (opcode)
      cpu_pkg::op_sub: ctrl.alu_op = cpu_pkg::alu_sub;
      cpu_pkg::op_and: ctrl.alu_op = cpu_pkg::alu_and;
      cpu_pkg::op_or:  ctrl.alu_op = cpu_pkg::alu_or;
      cpu_pkg::op_xor: ctrl.alu_op = cpu_pkg::alu_xor;
      cpu_pkg::op_slt: ctrl.alu_op = cpu_pkg::alu_slt;
      default:         ctrl.alu_op = cpu_pkg::alu_add;
    endcase
  end

  //////////////////////////////
  // register file

  assign wb_en = mem_wb.valid && mem_wb.reg_write && (mem_wb.dst != '0);

  always_ff @(posedge clk) begin
    if (wb_en) begin
      regs[mem_wb.dst] <= mem_wb.wb_data;
    end
  end

  // same-cycle writeback is seen here
  always_comb begin
    if (rs == '0) begin
      rs_data = '0;
    end else if (wb_en && (mem_wb.dst == rs)) begin
      rs_data = mem_wb.wb_data;
    end else begin
      rs_data = regs[rs];
    end
    if (rt == '0) begin
      rt_data = '0;
    end else if (wb_en && (mem_wb.dst == rt)) begin
      rt_data = mem_wb.wb_data;
    end else begin
      rt_data = regs[rt];
    end
  end

  assign reg_rdata = (reg_raddr == '0) ? '0 : regs[reg_raddr];

  //////////////////////////////
  // load-use hazard

  assign uses_rs = ctrl.reg_write || ctrl.mem_write;
  assign uses_rt = ctrl.reg_dst || ctrl.mem_write;

  assign stall = if_id.valid && id_ex.valid && id_ex.ctrl.mem_read && (id_ex.dst != '0) &&
                 ((uses_rs && (id_ex.dst == rs)) || (uses_rt && (id_ex.dst == rt)));

  always_ff @(posedge clk) begin
    if (!rst_n || start || stall) begin
      id_ex.valid <= 1'b0;
    end else begin
      id_ex.valid <= if_id.valid;
      id_ex.ctrl  <= ctrl;
      id_ex.rs    <= rs;
      id_ex.rt    <= rt;
      id_ex.dst   <= ctrl.reg_dst ? rd : rt;
      id_ex.op_a  <= rs_data;
      id_ex.op_b  <= rt_data;
      id_ex.imm   <= if_id.instr[15:0];
    end
  end

endmodule

//--- logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  logic              busy,
  input  logic              stall,
  input  cpu_pkg::dbg_mem_t imem_dbg,
  output cpu_pkg::if_id_t   if_id
);

  logic [cpu_pkg::data_width-1:0]     imem [2**cpu_pkg::mem_addr_width];
  logic [cpu_pkg::mem_addr_width-1:0] pc;
  logic [cpu_pkg::data_width-1:0]     instr;
  logic                               running;

  assign instr = imem[pc];

  // loaded over apb while idle
  always_ff @(posedge clk) begin
    if (imem_dbg.en && imem_dbg.write) begin
      imem[imem_dbg.addr] <= imem_dbg.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || start) begin
      pc          <= '0;
      running     <= start;
      if_id.valid <= 1'b0;
    end else if (!stall) begin
      if (running && busy) begin
        pc          <= pc + 1'b1;
        if_id.valid <= 1'b1;
        if_id.instr <= instr;
        // nothing past the halt is issued
        if (instr[31:26] == cpu_pkg::op_halt) begin
          running <= 1'b0;
        end
      end else begin
        if_id.valid <= 1'b0;
      end
    end
  end

endmodule

//--- logic/cpu_pkg.sv
package cpu_pkg;

  localparam int data_width     = 32;
  localparam int reg_addr_width = 5;
  localparam int mem_addr_width = 6;
  localparam int imm_width      = 16;
  localparam int opcode_width   = 6;
  localparam int apb_addr_width = 12;

  // opcodes, bits 31..26 of the instruction
  localparam logic [opcode_width-1:0] op_nop  = 6'd0;
  localparam logic [opcode_width-1:0] op_add  = 6'd1;
  localparam logic [opcode_width-1:0] op_sub  = 6'd2;
  localparam logic [opcode_width-1:0] op_and  = 6'd3;
  localparam logic [opcode_width-1:0] op_or   = 6'd4;
  localparam logic [opcode_width-1:0] op_xor  = 6'd5;
  localparam logic [opcode_width-1:0] op_slt  = 6'd6;
  localparam logic [opcode_width-1:0] op_addi = 6'd7;
  localparam logic [opcode_width-1:0] op_lw   = 6'd8;
  localparam logic [opcode_width-1:0] op_sw   = 6'd9;
  localparam logic [opcode_width-1:0] op_halt = 6'h3f;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt
  } alu_op_t;

  // apb byte address map
  localparam logic [apb_addr_width-1:0] apb_imem_base = 12'h000;
  localparam logic [apb_addr_width-1:0] apb_dmem_base = 12'h100;
  localparam logic [apb_addr_width-1:0] apb_reg_base  = 12'h200;
  localparam logic [apb_addr_width-1:0] apb_ctrl_addr = 12'h300;

  typedef struct packed {
    alu_op_t alu_op;
    logic    alu_src;
    logic    reg_dst;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    halt;
  } ctrl_t;

  typedef struct packed {
    logic                  valid;
    logic [data_width-1:0] instr;
  } if_id_t;

  typedef struct packed {
    logic                      valid;
    ctrl_t                     ctrl;
    logic [reg_addr_width-1:0] rs;
    logic [reg_addr_width-1:0] rt;
    logic [reg_addr_width-1:0] dst;
    logic [data_width-1:0]     op_a;
    logic [data_width-1:0]     op_b;
    logic [imm_width-1:0]      imm;
  } id_ex_t;

  typedef struct packed {
    logic                      valid;
    logic                      reg_write;
    logic                      mem_read;
    logic                      mem_write;
    logic                      halt;
    logic [reg_addr_width-1:0] dst;
    logic [data_width-1:0]     alu_result;
    logic [data_width-1:0]     store_data;
  } ex_mem_t;

  // also the register write port and a forwarding source
  typedef struct packed {
    logic                      valid;
    logic                      reg_write;
    logic                      halt;
    logic [reg_addr_width-1:0] dst;
    logic [data_width-1:0]     wb_data;
  } mem_wb_t;

  typedef struct packed {
    logic                      en;
    logic                      write;
    logic [mem_addr_width-1:0] addr;
    logic [data_width-1:0]     wdata;
  } dbg_mem_t;

endpackage
